// ==== Makefile ====
# Verilator flow for the cache memory subsystem
TOP = tb_mem_sys

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --top-module mem_sys_top -f verilog.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f verilog.f
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "Testbench passed"

clean:
	rm -rf obj_dir

// ==== cache_array.sv ====
`timescale 1ns/1ps

module cache_array (
	input  logic        clk,
	input  logic        rst_n,
	cache_port_if.array port
);
	import cache_pkg::*;

	logic [LINE_W-1:0]   line_mem [NUM_SETS]; // Line storage, no reset
	logic [TAG_W-1:0]    tag_mem  [NUM_SETS]; // Tag per set
	logic [NUM_SETS-1:0] valid_q;             // Set holds a line
	logic [NUM_SETS-1:0] dirty_q;             // Line differs from memory

	logic [TAG_W-1:0]    req_tag;
	logic [INDEX_W-1:0]  req_index;

	assign req_tag   = port.addr[LINE_ADDR_W-1 -: TAG_W]; // Upper bits of line address
	assign req_index = port.addr[INDEX_W-1:0];

	// Combinational lookup of the indexed set
	assign port.hit       = port.re && valid_q[req_index] && (tag_mem[req_index] == req_tag);
	assign port.dirty_out = valid_q[req_index] && dirty_q[req_index]; // Only a valid line is dirty
	assign port.tag_out   = tag_mem[req_index];
	assign port.rd_line   = line_mem[req_index];

	// Status bits, cleared so every set starts empty
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			valid_q <= '0;
			dirty_q <= '0;
		end else if (port.we) begin
			valid_q[req_index] <= 1'b1;
			dirty_q[req_index] <= port.dirty_in; // Clean on refill, set on write
		end
	end

	// Line and tag written together on fill or write hit
	always_ff @(posedge clk) begin
		if (port.we) begin
			line_mem[req_index] <= port.wr_line;
			tag_mem[req_index]  <= req_tag;
		end
	end

endmodule

// ==== cache_controller.sv ====
`timescale 1ns/1ps

module cache_controller (
	input  logic                              clk,
	input  logic                              rst_n,
	input  logic                              i_i_acc,   // Instruction request level
	input  logic                              i_d_acc,   // Data request level
	input  logic                              i_read,
	input  logic                              i_write,
	input  logic [cache_pkg::ADDR_W-1:0]      i_addr,    // Shared by both requests
	input  logic [cache_pkg::WORD_W-1:0]      i_wr_data,
	cache_port_if.ctrl                        i_port,
	cache_port_if.ctrl                        d_port,
	output logic                              o_m_re,
	output logic                              o_m_we,
	output logic [cache_pkg::LINE_ADDR_W-1:0] o_m_addr,
	output logic [cache_pkg::LINE_W-1:0]      o_m_data,
	input  logic                              i_mem_rdy,
	input  logic [cache_pkg::LINE_W-1:0]      i_m_line,
	output logic                              o_i_rdy,
	output logic                              o_d_rdy,
	output logic [cache_pkg::WORD_W-1:0]      o_instr,
	output logic [cache_pkg::WORD_W-1:0]      o_rd_data
);
	import cache_pkg::*;

	ctrl_state_t            state_q;
	ctrl_state_t            state_d;
	logic                   serve_i_q;  // Miss in flight belongs to the instruction side
	logic [TAG_W-1:0]       tag;
	logic [INDEX_W-1:0]     index;
	logic [OFFSET_W-1:0]    offset;
	logic [LINE_ADDR_W-1:0] line_addr;

	// Replace one word of a line with the processor's write data
	function automatic logic [LINE_W-1:0] merge_word(
		input logic [LINE_W-1:0]   line,
		input logic [WORD_W-1:0]   word,
		input logic [OFFSET_W-1:0] off
	);
		logic [LINE_W-1:0] merged;
		merged = line;
		merged[off*WORD_W +: WORD_W] = word;
		return merged;
	endfunction

	assign tag       = i_addr[ADDR_W-1 -: TAG_W];
	assign index     = i_addr[OFFSET_W +: INDEX_W];
	assign offset    = i_addr[OFFSET_W-1:0];
	assign line_addr = {tag, index};

	// Both arrays always index with the processor address
	assign i_port.addr = line_addr;
	assign d_port.addr = line_addr;

	// Addressed word of each cache line
	assign o_instr   = i_port.rd_line[offset*WORD_W +: WORD_W];
	assign o_rd_data = d_port.rd_line[offset*WORD_W +: WORD_W];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state_q   <= IDLE;
			serve_i_q <= 1'b0;
		end else begin
			state_q <= state_d;
			if (state_q == IDLE) begin
				serve_i_q <= i_i_acc; // Instruction wins the memory when both miss
			end
		end
	end

	always_comb begin
		state_d          = state_q;
		i_port.re        = 1'b0;
		i_port.we        = 1'b0;
		i_port.dirty_in  = 1'b0;         // Instruction lines are never modified
		i_port.wr_line   = i_m_line;
		d_port.re        = 1'b0;
		d_port.we        = 1'b0;
		d_port.dirty_in  = 1'b0;
		d_port.wr_line   = i_m_line;
		o_m_re           = 1'b0;
		o_m_we           = 1'b0;
		o_m_addr         = line_addr;
		o_m_data         = d_port.rd_line; // Victim line on write-back
		o_i_rdy          = 1'b0;
		o_d_rdy          = !i_d_acc;      // Nothing asked, nothing pending

		case (state_q)
			IDLE: begin
				i_port.re = i_i_acc;
				d_port.re = i_d_acc;
				if (i_i_acc && i_port.hit) begin
					o_i_rdy = 1'b1;                  // Instruction hit
				end else if (i_i_acc) begin
					state_d = SERVICE_MISS;          // Instruction miss
				end else if (i_d_acc && i_read && d_port.hit) begin
					o_d_rdy = 1'b1;                  // Data read hit
				end else if (i_d_acc && i_write && d_port.hit) begin
					d_port.we       = 1'b1;          // Write hit, line becomes dirty
					d_port.dirty_in = 1'b1;
					d_port.wr_line  = merge_word(d_port.rd_line, i_wr_data, offset);
					o_d_rdy         = 1'b1;
				end else if (i_d_acc && d_port.dirty_out) begin
					state_d = WRITE_BACK;            // Victim must go out first
				end else if (i_d_acc) begin
					state_d = SERVICE_MISS;          // Clean data miss
				end
			end

			WRITE_BACK: begin
				d_port.re = 1'b1;                    // Keep victim tag and line visible
				o_m_we    = 1'b1;
				o_m_addr  = {d_port.tag_out, index};
				if (i_mem_rdy) begin
					state_d = SERVICE_MISS;          // Continue as a clean miss
				end
			end

			SERVICE_MISS: begin
				o_m_re = 1'b1;                       // Held until memory answers
				if (i_mem_rdy) begin
					if (serve_i_q) begin
						i_port.we = 1'b1;            // Instruction refill
						state_d   = WRITE_RETURN;
					end else if (i_write) begin
						// Write allocate, word merged into the refill
						d_port.we       = 1'b1;
						d_port.dirty_in = 1'b1;
						d_port.wr_line  = merge_word(i_m_line, i_wr_data, offset);
						o_d_rdy         = 1'b1;
						state_d         = IDLE;
					end else begin
						d_port.we = 1'b1;            // Clean data refill
						state_d   = WRITE_RETURN;
					end
				end
			end

			WRITE_RETURN: begin
				// Refilled line re-read from the array
				if (serve_i_q) begin
					i_port.re = 1'b1;
					o_i_rdy   = 1'b1;
				end else begin
					d_port.re = 1'b1;
					o_d_rdy   = 1'b1;
				end
				state_d = IDLE;
			end

			default: begin
				state_d = IDLE;
			end
		endcase
	end

endmodule

// ==== cache_pkg.sv ====
package cache_pkg;

	// Processor address split: tag | index | offset
	localparam int ADDR_W      = 16;                  // Processor byte-free word address
	localparam int TAG_W       = 8;                   // Upper address bits
	localparam int INDEX_W     = 6;                   // Set select
	localparam int OFFSET_W    = 2;                   // Word within line
	localparam int NUM_SETS    = 2 ** INDEX_W;        // Sets per direct-mapped cache

	// Data widths
	localparam int WORD_W         = 16;               // One processor word
	localparam int LINE_W         = 64;               // One cache line
	localparam int WORDS_PER_LINE = LINE_W / WORD_W;  // Four words
	localparam int LINE_ADDR_W    = TAG_W + INDEX_W;  // Tag concatenated with index

	// Backing memory
	localparam int MEM_LINES   = 2 ** LINE_ADDR_W;    // Full line address space
	localparam int MEM_LATENCY = 4;                   // Held strobe cycles before ready
	localparam int MEM_CNT_W   = $clog2(MEM_LATENCY); // Latency counter width

	// Miss handling states of the controller
	typedef enum logic [1:0] {
		IDLE         = 2'b00, // Lookup, hits answered here
		WRITE_RETURN = 2'b01, // Refilled line read back to processor
		SERVICE_MISS = 2'b10, // Line read from memory
		WRITE_BACK   = 2'b11  // Dirty victim written to memory
	} ctrl_state_t;

endpackage

// ==== cache_port_if.sv ====
`timescale 1ns/1ps

interface cache_port_if;
	import cache_pkg::*;

	// Controller to array
	logic [LINE_ADDR_W-1:0] addr;      // Tag and index of the request
	logic                   re;        // Lookup enable
	logic                   we;        // Line fill / write
	logic                   dirty_in;  // Dirty bit stored with the fill
	logic [LINE_W-1:0]      wr_line;   // Line to store

	// Array to controller
	logic                   hit;       // Valid and tag match
	logic                   dirty_out; // Indexed set holds modified data
	logic [TAG_W-1:0]       tag_out;   // Stored tag, victim address on eviction
	logic [LINE_W-1:0]      rd_line;   // Stored line of the indexed set

	modport ctrl (
		output addr,
		output re,
		output we,
		output dirty_in,
		output wr_line,
		input  hit,
		input  dirty_out,
		input  tag_out,
		input  rd_line
	);

	modport array (
		input  addr,
		input  re,
		input  we,
		input  dirty_in,
		input  wr_line,
		output hit,
		output dirty_out,
		output tag_out,
		output rd_line
	);

endinterface

// ==== main_mem.sv ====
`timescale 1ns/1ps

module main_mem (
	input  logic                               clk,
	input  logic                               rst_n,
	input  logic                               i_re,
	input  logic                               i_we,
	input  logic [cache_pkg::LINE_ADDR_W-1:0]  i_addr,
	input  logic [cache_pkg::LINE_W-1:0]       i_data,
	output logic                               o_rdy,
	output logic [cache_pkg::LINE_W-1:0]       o_line
);
	import cache_pkg::*;

	logic [LINE_W-1:0]    mem_q [MEM_LINES]; // Backing line storage
	logic [MEM_LINES-1:0] written_q;         // Line has been written at least once
	logic [MEM_CNT_W-1:0] cnt_q;             // Cycles the strobe has been held
	logic                 strobe;
	logic [LINE_W-1:0]    fresh_line;        // Contents of a never-written line

	assign strobe = i_re || i_we;

	// Ready on the last held cycle of the access
	assign o_rdy = strobe && (cnt_q == MEM_CNT_W'(MEM_LATENCY - 1));

	// Latency counter, restarts whenever the strobe drops or an access ends
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cnt_q <= '0;
		end else if (!strobe || o_rdy) begin
			cnt_q <= '0;
		end else begin
			cnt_q <= cnt_q + 1'b1;
		end
	end

	// Each word of an unwritten line reads back its own word address
	always_comb begin
		for (int w = 0; w < WORDS_PER_LINE; w++) begin
			fresh_line[w*WORD_W +: WORD_W] = {i_addr, OFFSET_W'(w)};
		end
	end

	assign o_line = written_q[i_addr] ? mem_q[i_addr] : fresh_line;

	// Written bitmap
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			written_q <= '0;
		end else if (o_rdy && i_we) begin
			written_q[i_addr] <= 1'b1;
		end
	end

	// Write commits on the ready edge
	always_ff @(posedge clk) begin
		if (o_rdy && i_we) begin
			mem_q[i_addr] <= i_data;
		end
	end

endmodule

// ==== mem_sys_top.sv ====
`timescale 1ns/1ps

module mem_sys_top (
	input  logic                         clk,
	input  logic                         rst_n,
	input  logic                         i_i_acc,
	input  logic                         i_d_acc,
	input  logic                         i_read,
	input  logic                         i_write,
	input  logic [cache_pkg::ADDR_W-1:0] i_addr,
	input  logic [cache_pkg::WORD_W-1:0] i_wr_data,
	output logic                         o_i_rdy,
	output logic                         o_d_rdy,
	output logic [cache_pkg::WORD_W-1:0] o_instr,
	output logic [cache_pkg::WORD_W-1:0] o_rd_data
);
	import cache_pkg::*;

	cache_port_if i_port ();             // Controller to instruction cache
	cache_port_if d_port ();             // Controller to data cache

	logic                   m_re;
	logic                   m_we;
	logic [LINE_ADDR_W-1:0] m_addr;
	logic [LINE_W-1:0]      m_data;
	logic                   mem_rdy;
	logic [LINE_W-1:0]      m_line;

	cache_controller ctrl_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.i_i_acc   (i_i_acc),
		.i_d_acc   (i_d_acc),
		.i_read    (i_read),
		.i_write   (i_write),
		.i_addr    (i_addr),
		.i_wr_data (i_wr_data),
		.i_port    (i_port.ctrl),
		.d_port    (d_port.ctrl),
		.o_m_re    (m_re),
		.o_m_we    (m_we),
		.o_m_addr  (m_addr),
		.o_m_data  (m_data),
		.i_mem_rdy (mem_rdy),
		.i_m_line  (m_line),
		.o_i_rdy   (o_i_rdy),
		.o_d_rdy   (o_d_rdy),
		.o_instr   (o_instr),
		.o_rd_data (o_rd_data)
	);

	cache_array icache_i (.clk(clk), .rst_n(rst_n), .port(i_port.array));

	cache_array dcache_i (.clk(clk), .rst_n(rst_n), .port(d_port.array));

	main_mem mem_i (
		.clk    (clk),
		.rst_n  (rst_n),
		.i_re   (m_re),
		.i_we   (m_we),
		.i_addr (m_addr),
		.i_data (m_data),
		.o_rdy  (mem_rdy),
		.o_line (m_line)
	);

endmodule

// ==== tb_mem_sys.sv ====
`timescale 1ns/1ps

module tb_mem_sys;
	import cache_pkg::*;

	localparam int TIMEOUT_CYCLES = 200; // Longest wait for any ready

	logic              clk = 1'b0;
	logic              rst_n;
	logic              i_acc;
	logic              d_acc;
	logic              rd;
	logic              wr;
	logic [ADDR_W-1:0] addr;
	logic [WORD_W-1:0] wr_data;
	logic              i_rdy;
	logic              d_rdy;
	logic [WORD_W-1:0] instr;
	logic [WORD_W-1:0] rd_data;

	logic [WORD_W-1:0] model_mem [2**ADDR_W]; // Expected word at every address
	int                seed;
	int                err_cnt;
	int                test_err;              // err_cnt when the test began
	int                pass_cnt;
	int                fail_cnt;
	int                last_wait;             // Cycles before the last ready, 0 on a hit
	bit                timed_out;

	mem_sys_top dut_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.i_i_acc   (i_acc),
		.i_d_acc   (d_acc),
		.i_read    (rd),
		.i_write   (wr),
		.i_addr    (addr),
		.i_wr_data (wr_data),
		.o_i_rdy   (i_rdy),
		.o_d_rdy   (d_rdy),
		.o_instr   (instr),
		.o_rd_data (rd_data)
	);

	always #5 clk = ~clk;                    // 10 ns period

	assert property (@(posedge clk) disable iff (!rst_n) i_rdy |-> i_acc)
		else note_error("Error: o_i_rdy high with no instruction request");
	assert property (@(posedge clk) disable iff (!rst_n) !d_acc |-> d_rdy)
		else note_error("Error: o_d_rdy low with no data request");
	// Instruction side is answered first when both are held
	assert property (@(posedge clk) disable iff (!rst_n) (i_acc && d_acc) |-> !d_rdy)
		else note_error("Error: data answered while an instruction request waits");

	function automatic void note_error(input string msg);
		$display("%s", msg);
		err_cnt++;
	endfunction

	function automatic void check_word(input string name, input logic [ADDR_W-1:0] a,
		input logic [WORD_W-1:0] want, input logic [WORD_W-1:0] got);
		if (!timed_out) begin
			assert (got === want)
			else begin
				$display("Fail %s at address 0x%h: expected 0x%h, got 0x%h", name, a, want, got);
				err_cnt++;
			end
		end
	endfunction

	function automatic void check_latency(input bit want_hit, input string what);
		if (!timed_out) begin
			assert ((last_wait == 0) == want_hit)
				else note_error({"Error: wrong hit or miss timing for ", what});
		end
	endfunction

	// Random tag and offset, index drawn from lo up to lo+span-1
	function automatic logic [ADDR_W-1:0] pick_addr(input int lo, input int span);
		logic [TAG_W-1:0]    t;
		logic [INDEX_W-1:0]  idx;
		logic [OFFSET_W-1:0] off;
		t   = TAG_W'($random(seed));
		idx = INDEX_W'(lo + int'($unsigned($random(seed)) % span));
		off = OFFSET_W'($random(seed));
		return {t, idx, off};
	endfunction

	// Sample at the falling edge so the next rising edge takes the ready
	task automatic wait_ready(input bit instr_side, input string what);
		int n;
		n = 0;
		@(negedge clk);
		while (!(instr_side ? i_rdy : d_rdy) && n < TIMEOUT_CYCLES) begin
			@(negedge clk);
			n++;
		end
		last_wait = n;
		if (!(instr_side ? i_rdy : d_rdy)) begin
			$display("Timeout: %s got no ready within %0d cycles", what, TIMEOUT_CYCLES);
			timed_out = 1'b1;
		end
	endtask

	task automatic fetch(input logic [ADDR_W-1:0] a, output logic [WORD_W-1:0] got);
		got = '0;
		if (!timed_out) begin
			addr  = a;
			i_acc = 1'b1;
			wait_ready(1'b1, "instruction fetch");
			got = instr;
			@(posedge clk);
			#1;
			i_acc = 1'b0;
		end
	endtask

	task automatic data_read(input logic [ADDR_W-1:0] a, output logic [WORD_W-1:0] got);
		got = '0;
		if (!timed_out) begin
			addr  = a;
			d_acc = 1'b1;
			rd    = 1'b1;
			wait_ready(1'b0, "data read");
			got = rd_data;
			@(posedge clk);
			#1;
			d_acc = 1'b0;
			rd    = 1'b0;
		end
	endtask

	task automatic data_write(input logic [ADDR_W-1:0] a, input logic [WORD_W-1:0] w);
		if (!timed_out) begin
			addr    = a;
			wr_data = w;
			d_acc   = 1'b1;
			wr      = 1'b1;
			wait_ready(1'b0, "data write");
			@(posedge clk);
			#1;
			d_acc = 1'b0;
			wr    = 1'b0;
			model_mem[a] = w;                    // Processor write recorded
		end
	endtask

	// Same address on both sides, instruction ready first
	task automatic fetch_and_read(input logic [ADDR_W-1:0] a, output logic [WORD_W-1:0] ig,
		output logic [WORD_W-1:0] dg);
		ig = '0;
		dg = '0;
		if (!timed_out) begin
			addr  = a;
			i_acc = 1'b1;
			d_acc = 1'b1;
			rd    = 1'b1;
			wait_ready(1'b1, "joint instruction fetch");
			ig    = instr;
			@(posedge clk);
			#1;
			i_acc = 1'b0;                        // Data stays held
			wait_ready(1'b0, "joint data read");
			dg    = rd_data;
			@(posedge clk);
			#1;
			d_acc = 1'b0;
			rd    = 1'b0;
		end
	endtask

	// All four words of the line, expected to be cached
	task automatic check_line(input logic [ADDR_W-1:0] a);
		logic [ADDR_W-1:0] b;
		logic [WORD_W-1:0] got;
		for (int off = 0; off < WORDS_PER_LINE; off++) begin
			b = {a[ADDR_W-1:OFFSET_W], OFFSET_W'(off)};
			data_read(b, got);
			check_latency(1'b1, "read of a cached line");
			check_word("o_rd_data", b, model_mem[b], got);
		end
	endtask

	function automatic void begin_test();
		test_err = err_cnt;
	endfunction

	function automatic void end_test(input string name);
		if (err_cnt == test_err && !timed_out) begin
			pass_cnt++;
			$display("Test %s: ok", name);
		end else begin
			fail_cnt++;
			$display("Test %s: %0d errors", name, err_cnt - test_err);
		end
	endfunction

	initial begin
		logic [ADDR_W-1:0] a;
		logic [ADDR_W-1:0] b;
		logic [ADDR_W-1:0] fetched [4];
		logic [WORD_W-1:0] got;
		logic [WORD_W-1:0] got_d;

		seed      = 32'h5eeb;
		err_cnt   = 0;
		pass_cnt  = 0;
		fail_cnt  = 0;
		last_wait = 0;
		timed_out = 1'b0;
		rst_n     = 1'b0;
		i_acc     = 1'b0;
		d_acc     = 1'b0;
		rd        = 1'b0;
		wr        = 1'b0;
		addr      = '0;
		wr_data   = '0;
		for (int k = 0; k < 2**ADDR_W; k++) begin
			model_mem[k] = WORD_W'(k);           // Unwritten word reads its own address
		end

		// Indices 0..15 hold instructions, 16..51 data, 56..63 joint requests
		begin_test();
		repeat (3) begin
			@(posedge clk);
			assert (i_rdy == 1'b0) else note_error("Error: o_i_rdy high during reset");
		end
		#1;
		rst_n = 1'b1;
		for (int k = 0; k < 4; k++) begin
			fetched[k] = pick_addr(4 * k, 4);
			fetch(fetched[k], got);
			check_latency(1'b0, "cold instruction fetch");
			check_word("o_instr", fetched[k], model_mem[fetched[k]], got);
		end
		end_test("reset and cold fetch");

		begin_test();
		for (int k = 0; k < 4; k++) begin
			fetch(fetched[k], got);
			check_latency(1'b1, "repeated instruction fetch");
			check_word("o_instr", fetched[k], model_mem[fetched[k]], got);
		end
		end_test("instruction hit");

		begin_test();
		for (int k = 0; k < 4; k++) begin
			a = pick_addr(16 + 4 * k, 4);
			data_read(a, got);
			check_latency(1'b0, "cold data read");
			check_word("o_rd_data", a, model_mem[a], got);
			check_line(a);
		end
		end_test("data read miss and hit");

		begin_test();
		for (int k = 0; k < 4; k++) begin
			a = pick_addr(32 + k, 1);
			data_read(a, got);                   // Bring the line in first
			data_write(a, WORD_W'($random(seed)));
			check_latency(1'b1, "write to a cached line");
			check_line(a);
			b = pick_addr(40 + k, 1);
			data_write(b, WORD_W'($random(seed)));
			check_latency(1'b0, "write to an uncached line");
			check_line(b);
		end
		end_test("data write hit and miss");

		begin_test();
		for (int k = 0; k < 4; k++) begin
			a = pick_addr(48 + k, 1);
			data_write(a, WORD_W'($random(seed)));
			b = {a[ADDR_W-1 -: TAG_W] ^ 8'h5a, a[ADDR_W-TAG_W-1:0]}; // Same set, other tag
			data_read(b, got);
			check_latency(1'b0, "read that evicts a dirty line");
			check_word("o_rd_data", b, model_mem[b], got);
			data_read(a, got);
			check_latency(1'b0, "read of the evicted line");
			check_word("o_rd_data", a, model_mem[a], got);
			check_line(a);
		end
		end_test("dirty eviction");

		begin_test();
		for (int k = 0; k < 4; k++) begin
			a = pick_addr(56 + 2 * k, 2);
			for (int j = 0; j < 2; j++) begin    // Both miss, then both hit
				fetch_and_read(a, got, got_d);
				check_word("o_instr", a, model_mem[a], got);
				check_word("o_rd_data", a, model_mem[a], got_d);
			end
		end
		end_test("joint requests");

		$display("Tests: %0d passed, %0d failed, %0d errors", pass_cnt, fail_cnt, err_cnt);
		if (fail_cnt == 0 && err_cnt == 0 && !timed_out) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

// ==== verilog.f ====
cache_pkg.sv
cache_port_if.sv
cache_array.sv
main_mem.sv
cache_controller.sv
mem_sys_top.sv
tb_mem_sys.sv
